// ==== project.f ====
hw/match_pkg.sv
hw/expn_dfa.sv
hw/stream_matcher.sv
hw/stream_table.sv
hw/sig_count_top.sv
bench/sig_count_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= sig_count_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass message shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/sig_count_tb.sv ====
`timescale 1ns/100ps

module sig_count_tb;

   localparam int NUM_STREAMS   = 64;
   localparam int ID_W          = $clog2(NUM_STREAMS);
   localparam int CLK_PERIOD    = 10;
   localparam int RESET_CYCLES  = 3;
   // Stimulus size, also the base of the watchdog time
   localparam int DIRECTED_PKTS = 20;
   localparam int RAND_PKTS     = 24;
   localparam int MAX_PKT_LEN   = 24;
   localparam int PKT_OVERHEAD  = 8;
   localparam int MAX_CFG       = 40;
   // Each byte may take an idle cycle, then doubled as margin
   localparam int WATCHDOG_NS   = 2 * CLK_PERIOD * ((DIRECTED_PKTS + RAND_PKTS) *
      (2 * MAX_PKT_LEN + PKT_OVERHEAD) + 2 * MAX_CFG + RESET_CYCLES + 10);

   logic            clk;
   logic            rst_n;
   logic            load_state;
   logic [ID_W-1:0] stream_id;
   logic [7:0]      char_in;
   logic            char_in_vld;
   logic            eop;
   logic            cfg_wr;
   logic [ID_W-1:0] cfg_stream;
   logic            cfg_enable;
   logic [15:0]     count;
   logic            fired;

   // Check strobe and the values expected while it is high
   logic            chk;
   logic [15:0]     exp_count;
   logic            exp_fired;

   // Reference model: letters matched so far per stream, seen and enable bits
   int              saved_prog [NUM_STREAMS];
   bit              seen [NUM_STREAMS];
   bit              en [NUM_STREAMS];
   logic [15:0]     model_count;

   // Bytes of the next packet
   logic [7:0]      pkt_bytes [$];
   logic [7:0]      letters [4] = '{"E", "X", "P", "N"};
   // Filler alphabet, heavy on the word's letters so matches happen
   logic [7:0]      filler [16] = '{"E", "e", "X", "x", "P", "p", "N", "n",
                                    "E", "x", "A", "q", " ", "0", ".", "Z"};
   int              rand_streams [8] = '{1, 2, 3, 10, 11, 12, 40, 63};

   integer          seed;
   int              errors;
   int              checks;
   int              sid;

   sig_count_top #(.NUM_STREAMS(NUM_STREAMS)) u_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   count_matches: assert property (@(posedge clk) disable iff (!rst_n)
      chk |-> (count == exp_count))
      else
      begin
         errors = errors + 1;
         $display("** Error count: got 0x%h, expected 0x%h", $sampled(count),
            $sampled(exp_count));
      end

   fired_matches: assert property (@(posedge clk) disable iff (!rst_n)
      chk |-> (fired == exp_fired))
      else
      begin
         errors = errors + 1;
         $display("** Error fired: got 0x%h, expected 0x%h", $sampled(fired),
            $sampled(exp_fired));
      end

   // Letters of the word matched after one more character, 4 is a full match
   function automatic int next_progress(input int prog, input logic [7:0] c);
      logic [7:0] up;
      int         res;
      up = c;
      if (c >= "a" && c <= "z")
      begin
         up = c - 8'd32;
      end
      // A miss restarts, but an E is already a first letter
      res = (up == "E") ? 1 : 0;
      if (prog >= 1 && prog <= 3 && up == letters[prog])
      begin
         res = prog + 1;
      end
      return res;
   endfunction

   // Arm both assertions for the next cycle
   task automatic expect_outputs(input logic [15:0] c, input logic f);
      chk       <= 1'b1;
      exp_count <= c;
      exp_fired <= f;
      checks = checks + 1;
   endtask

   task automatic set_enable(input int s, input logic val);
      @(posedge clk);
      cfg_wr     <= 1'b1;
      cfg_stream <= ID_W'(s);
      cfg_enable <= val;
      en[s] = val;
      @(posedge clk);
      cfg_wr <= 1'b0;
   endtask

   task automatic load_string(input string s);
      for (int i = 0; i < s.len(); i++)
      begin
         pkt_bytes.push_back(s[i]);
      end
   endtask

   task automatic add_random_bytes(input int n);
      int idx;
      for (int i = 0; i < n; i++)
      begin
         idx = $random(seed) & 15;
         pkt_bytes.push_back(filler[idx]);
      end
   endtask

   // One framed packet from pkt_bytes, with checks at start, eop and after eop
   task automatic send_packet(input int s);
      int prog;
      bit flag;
      @(posedge clk);
      stream_id  <= ID_W'(s);
      load_state <= 1'b1;
      // Never saved means a clean start
      prog = seen[s] ? saved_prog[s] : 0;
      flag = 1'b0;
      @(posedge clk);
      load_state <= 1'b0;
      expect_outputs(model_count, 1'b0);
      @(posedge clk);
      chk <= 1'b0;
      foreach (pkt_bytes[i])
      begin
         char_in     <= pkt_bytes[i];
         char_in_vld <= 1'b1;
         prog = next_progress(prog, pkt_bytes[i]);
         if (prog == 4)
         begin
            flag = 1'b1;
         end
         // Sometimes an idle cycle between bytes
         if (($random(seed) & 7) == 0)
         begin
            @(posedge clk);
            char_in_vld <= 1'b0;
         end
         @(posedge clk);
      end
      char_in_vld <= 1'b0;
      // Two cycles after the last byte
      @(posedge clk);
      eop <= 1'b1;
      expect_outputs(model_count, flag);
      @(posedge clk);
      eop <= 1'b0;
      if (en[s])
      begin
         if (flag)
         begin
            model_count = model_count + 16'd1;
         end
         saved_prog[s] = prog;
         seen[s] = 1'b1;
         expect_outputs(model_count, flag);
      end
      else
      begin
         expect_outputs(model_count, 1'b0);
      end
      @(posedge clk);
      chk <= 1'b0;
      pkt_bytes.delete();
   endtask

   task automatic packet_of(input int s, input string txt);
      load_string(txt);
      send_packet(s);
   endtask

   initial
   begin
      seed = 32'h0dd549c0;
      errors = 0;
      checks = 0;
      model_count = 16'd0;
      rst_n = 1'b0;
      load_state = 1'b0;
      stream_id = '0;
      char_in = 8'h00;
      char_in_vld = 1'b0;
      eop = 1'b0;
      cfg_wr = 1'b0;
      cfg_stream = '0;
      cfg_enable = 1'b0;
      chk = 1'b0;
      exp_count = 16'd0;
      exp_fired = 1'b0;
      foreach (seen[i])
      begin
         seen[i] = 1'b0;
         en[i] = 1'b0;
         saved_prog[i] = 0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      // Clean outputs out of reset
      @(posedge clk);
      expect_outputs(16'd0, 1'b0);
      @(posedge clk);
      chk <= 1'b0;

      // Mixed case match, and one count for a doubled word
      set_enable(1, 1'b1);
      packet_of(1, "abcExPnxyz");
      packet_of(1, "expnEXPN");

      // Word split over two packets of one stream
      set_enable(2, 1'b1);
      packet_of(2, "helo EX");
      packet_of(2, "PN quit");

      // Partial words must stay in their own stream
      set_enable(3, 1'b1);
      set_enable(4, 1'b1);
      set_enable(5, 1'b1);
      set_enable(6, 1'b1);
      packet_of(3, "xEXP");
      packet_of(4, "N");
      packet_of(3, "n");
      packet_of(5, "ex");
      packet_of(6, "EX");
      packet_of(5, "p");
      packet_of(6, "x");
      packet_of(5, "n");
      packet_of(6, "pn");

      // Disabled stream counts nothing and saves nothing
      packet_of(9, "xEXPNx");
      packet_of(9, "EX");
      set_enable(9, 1'b1);
      packet_of(9, "PN");

      // Failure transitions
      packet_of(1, "zEEXPNq");
      packet_of(2, "EEEXPN");

      // Random traffic over a handful of streams
      set_enable(10, 1'b1);
      set_enable(11, 1'b1);
      set_enable(12, 1'b1);
      set_enable(63, 1'b1);
      for (int p = 0; p < RAND_PKTS; p++)
      begin
         if (($random(seed) & 3) == 0)
         begin
            set_enable(rand_streams[$random(seed) & 7], ($random(seed) & 1) != 0);
         end
         sid = rand_streams[$random(seed) & 7];
         add_random_bytes($random(seed) & 15);
         if (($random(seed) & 3) == 0)
         begin
            load_string("EEXPN");
         end
         add_random_bytes($random(seed) & 3);
         send_packet(sid);
      end

      repeat (2) @(posedge clk);
      $display("Run done: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
      begin
         $display("Everything OK");
      end
      else
      begin
         $display("Something failed");
      end
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, stimulus did not finish", WATCHDOG_NS);
      $display("Something failed");
      $finish;
   end

endmodule

// ==== hw/sig_count_top.sv ====
`timescale 1ns/100ps

module sig_count_top
#(
   parameter  int NUM_STREAMS = 64,
   localparam int ID_W        = $clog2(NUM_STREAMS)
)
(
   input  logic             clk,
   input  logic             rst_n,
   // Packet framing
   input  logic             load_state,
   input  logic [ID_W-1:0]  stream_id,
   input  match_pkg::byte_t char_in,
   input  logic             char_in_vld,
   input  logic             eop,
   // Enable table writes
   input  logic             cfg_wr,
   input  logic [ID_W-1:0]  cfg_stream,
   input  logic             cfg_enable,
   // Results
   output logic [15:0]      count,
   output logic             fired
);

   // Table lookups for the current stream
   logic enable;
   logic new_stream_id;

   // Matcher tells the table a state was saved
   logic save_pulse;

   stream_table #(.NUM_STREAMS(NUM_STREAMS)) u_stream_table
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .cfg_wr        (cfg_wr),
      .cfg_stream    (cfg_stream),
      .cfg_enable    (cfg_enable),
      .stream_id     (stream_id),
      .save_pulse    (save_pulse),
      .enable        (enable),
      .new_stream_id (new_stream_id)
   );

   stream_matcher #(.NUM_STREAMS(NUM_STREAMS)) u_stream_matcher
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .eop           (eop),
      .char_in_vld   (char_in_vld),
      .char_in       (char_in),
      .stream_id     (stream_id),
      .enable        (enable),
      .new_stream_id (new_stream_id),
      .save_pulse    (save_pulse),
      .count         (count),
      .fired         (fired)
   );

endmodule

// ==== hw/stream_table.sv ====
`timescale 1ns/100ps

module stream_table
#(
   parameter  int NUM_STREAMS = 64,
   localparam int ID_W        = $clog2(NUM_STREAMS)
)
(
   input  logic            clk,
   input  logic            rst_n,
   input  logic            cfg_wr,
   input  logic [ID_W-1:0] cfg_stream,
   input  logic            cfg_enable,
   input  logic [ID_W-1:0] stream_id,
   input  logic            save_pulse,
   output logic            enable,
   output logic            new_stream_id
);

   // Rule enable per stream
   logic [NUM_STREAMS-1:0] enable_bits;

   // Set once a stream had its state saved
   logic [NUM_STREAMS-1:0] seen_bits;

   // Configuration writes
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         enable_bits <= '0;
      end
      else if (cfg_wr)
      begin
         enable_bits[cfg_stream] <= cfg_enable;
      end
   end

   // Seen bits only ever get set, until reset
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         seen_bits <= '0;
      end
      else if (save_pulse)
      begin
         seen_bits[stream_id] <= 1'b1;
      end
   end

   // Lookups for the current stream
   assign enable        = enable_bits[stream_id];
   assign new_stream_id = ~seen_bits[stream_id];

   // Matcher may only save for a stream the table has enabled
   save_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
      save_pulse |-> enable)
      else $error("save_pulse for disabled stream %0h", stream_id);

endmodule

// ==== hw/stream_matcher.sv ====
`timescale 1ns/100ps

module stream_matcher
#(
   parameter  int NUM_STREAMS = 64,
   localparam int ID_W        = $clog2(NUM_STREAMS)
)
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               load_state,
   input  logic               eop,
   input  logic               char_in_vld,
   input  match_pkg::byte_t   char_in,
   input  logic [ID_W-1:0]    stream_id,
   input  logic               enable,
   input  logic               new_stream_id,
   output logic               save_pulse,
   output logic [15:0]        count,
   output logic               fired
);

   import match_pkg::*;

   // Saved automaton state, one entry per stream
   dfa_state_e state_mem [NUM_STREAMS];

   // Restore path into the automaton
   dfa_state_e state_in;
   logic       state_in_vld;

   // Automaton outputs
   dfa_state_e state_out;
   logic       accept_out;

   // Set once the word was seen in the current packet
   logic       pkt_match;

   // Save happens only for enabled streams at packet end
   assign save_pulse = eop & enable;

   assign fired = pkt_match;

   // Restore strobe, delayed one cycle from load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_in_vld <= 1'b0;
      end
      else
      begin
         state_in_vld <= load_state;
      end
   end

   // Restored value
   // A stream never saved before starts clean
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         if (new_stream_id)
         begin
            state_in <= S_IDLE;
         end
         else
         begin
            state_in <= state_mem[stream_id];
         end
      end
   end

   // Write back the final state of an enabled packet
   always_ff @(posedge clk)
   begin
      if (save_pulse)
      begin
         state_mem[stream_id] <= state_out;
      end
   end

   // Packet flag and global count
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         pkt_match <= 1'b0;
         count     <= 16'd0;
      end
      else
      begin
         // New packet, forget the last result
         if (load_state)
         begin
            pkt_match <= 1'b0;
         end

         // At most one count per packet however often the word shows
         if (accept_out)
         begin
            pkt_match <= 1'b1;
         end

         if (eop)
         begin
            if (enable)
            begin
               // Wraps at 16 bits
               count <= count + 16'(pkt_match);
            end
            else
            begin
               // Rule off for this stream, drop the result
               pkt_match <= 1'b0;
            end
         end
      end
   end

   expn_dfa u_expn_dfa
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (char_in),
      .char_in_vld  (char_in_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept_out   (accept_out)
   );

   // Packet start and end share the state memory port
   no_load_with_eop: assert property (@(posedge clk) disable iff (!rst_n)
      !(load_state && eop))
      else $error("load_state and eop together, stream %0h", stream_id);

   // A late character would miss the saved state
   no_char_with_eop: assert property (@(posedge clk) disable iff (!rst_n)
      !(char_in_vld && eop))
      else $error("char_in_vld with eop, char %0h", char_in);

endmodule

// ==== hw/expn_dfa.sv ====
`timescale 1ns/100ps

module expn_dfa
(
   input  logic               clk,
   input  logic               rst_n,
   input  match_pkg::byte_t   char_in,
   input  logic               char_in_vld,
   input  match_pkg::dfa_state_e state_in,
   input  logic               state_in_vld,
   output match_pkg::dfa_state_e state_out,
   output logic               accept_out
);

   import match_pkg::*;

   // Current automaton state
   dfa_state_e state_q;

   // State the next step starts from
   dfa_state_e base_state;

   // State after this cycle
   dfa_state_e next_state;

   // Folded input character
   byte_t      char_up;

   // One step of the automaton on an upper-case character
   function automatic dfa_state_e step(input dfa_state_e cur, input byte_t c);
      dfa_state_e nxt;
      // On the failure path an E can always begin a new word
      nxt = (c == CHAR_E) ? S_E : S_IDLE;
      case (cur)
         S_E:
         begin
            if (c == CHAR_X)
            begin
               nxt = S_EX;
            end
         end
         S_EX:
         begin
            if (c == CHAR_P)
            begin
               nxt = S_EXP;
            end
         end
         S_EXP:
         begin
            if (c == CHAR_N)
            begin
               nxt = S_EXPN;
            end
         end
         // S_IDLE and S_EXPN both restart from scratch
         default:
         begin
            nxt = (c == CHAR_E) ? S_E : S_IDLE;
         end
      endcase
      return nxt;
   endfunction

   assign char_up = fold_upper(char_in);

   // A restore in this cycle replaces the held state
   assign base_state = state_in_vld ? state_in : state_q;

   // Step only on a valid character
   always_comb
   begin
      next_state = base_state;
      if (char_in_vld)
      begin
         next_state = step(base_state, char_up);
      end
   end

   // State register
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= S_IDLE;
      end
      else
      begin
         state_q <= next_state;
      end
   end

   // Accept pulse one cycle after the N that closed the word
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         accept_out <= 1'b0;
      end
      else
      begin
         accept_out <= char_in_vld && (next_state == S_EXPN);
      end
   end

   assign state_out = state_q;

   // A restored state has to be one of the five legal encodings
   state_out_legal: assert property (@(posedge clk) disable iff (!rst_n)
      state_out inside {S_IDLE, S_E, S_EX, S_EXP, S_EXPN})
      else $error("state_out holds illegal encoding %0h", state_out);

endmodule

// ==== hw/match_pkg.sv ====
package match_pkg;

   // Width of one saved automaton state
   localparam int STATE_W = 3;

   // One input character
   typedef logic [7:0] byte_t;

   // Letters of the word, upper case
   localparam byte_t CHAR_E = 8'h45;
   localparam byte_t CHAR_X = 8'h58;
   localparam byte_t CHAR_P = 8'h50;
   localparam byte_t CHAR_N = 8'h4e;

   // Progress through "EXPN"
   // S_EXPN means the full word was the last thing seen
   typedef enum logic [STATE_W-1:0]
   {
      S_IDLE = 3'd0,
      S_E    = 3'd1,
      S_EX   = 3'd2,
      S_EXP  = 3'd3,
      S_EXPN = 3'd4
   } dfa_state_e;

   // Map a..z onto A..Z, pass everything else through
   function automatic byte_t fold_upper(input byte_t c);
      byte_t r;
      r = c;
      if (c >= 8'h61 && c <= 8'h7a)
      begin
         r = c - 8'h20;
      end
      return r;
   endfunction

endpackage
